// File: lc4_core.f
+incdir+logic
+incdir+testbench
logic/lc4_pkg.sv
logic/lc4_decoder.sv
logic/lc4_regfile.sv
logic/lc4_alu.sv
logic/lc4_pc_unit.sv
logic/lc4_core.sv
testbench/tb_lc4_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_lc4_core
FILELIST  := lc4_core.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv logic/*.svh testbench/*.sv testbench/*.svh)
PASS_MSG  := SIMULATION PASSED

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_lc4_program.svh
`ifndef TB_LC4_PROGRAM_SVH
`define TB_LC4_PROGRAM_SVH

// One retiring instruction and the trace it has to show
typedef struct packed {
   logic [`LC4_WORD_W-1:0]    pc;
   logic [`LC4_WORD_W-1:0]    insn;
   logic                      rf_we;
   logic [`LC4_REG_SEL_W-1:0] rf_wsel;
   logic [`LC4_WORD_W-1:0]    rf_wdata;
   logic [2:0]                nzp_new;
   logic                      dmem_we;
   logic [`LC4_WORD_W-1:0]    dmem_addr;
   logic [`LC4_WORD_W-1:0]    dmem_data;
} prog_row_t;

localparam int PROG_ROWS = 30;

prog_row_t prog [PROG_ROWS];

// Rows in execution order, each word sits at its own pc
// pc, insn, rf_we, rf_wsel, rf_wdata, nzp_new, dmem_we, dmem_addr, dmem_data
task automatic fill_program_table();
   // CONST R0 #5, CONST R1 #-3
   prog[0]  = '{16'h8200, 16'h9005, 1'b1, 3'd0, 16'h0005, 3'b001, 1'b0, 16'h0000, 16'h0000};
   prog[1]  = '{16'h8201, 16'h93FD, 1'b1, 3'd1, 16'hFFFD, 3'b100, 1'b0, 16'h0000, 16'h0000};
   // ADD, SUB, ADDI down to zero
   prog[2]  = '{16'h8202, 16'h1401, 1'b1, 3'd2, 16'h0002, 3'b001, 1'b0, 16'h0000, 16'h0000};
   prog[3]  = '{16'h8203, 16'h1650, 1'b1, 3'd3, 16'hFFF8, 3'b100, 1'b0, 16'h0000, 16'h0000};
   prog[4]  = '{16'h8204, 16'h183B, 1'b1, 3'd4, 16'h0000, 3'b010, 1'b0, 16'h0000, 16'h0000};
   // AND, NOT, OR, XOR, ANDI
   prog[5]  = '{16'h8205, 16'h5A01, 1'b1, 3'd5, 16'h0005, 3'b001, 1'b0, 16'h0000, 16'h0000};
   prog[6]  = '{16'h8206, 16'h5C08, 1'b1, 3'd6, 16'hFFFA, 3'b100, 1'b0, 16'h0000, 16'h0000};
   prog[7]  = '{16'h8207, 16'h5413, 1'b1, 3'd2, 16'hFFFD, 3'b100, 1'b0, 16'h0000, 16'h0000};
   prog[8]  = '{16'h8208, 16'h5A58, 1'b1, 3'd5, 16'hFFF8, 3'b100, 1'b0, 16'h0000, 16'h0000};
   prog[9]  = '{16'h8209, 16'h5866, 1'b1, 3'd4, 16'h0004, 3'b001, 1'b0, 16'h0000, 16'h0000};
   // Base pointer R6 = 0x40, two stores then two loads back
   prog[10] = '{16'h820A, 16'h9C40, 1'b1, 3'd6, 16'h0040, 3'b001, 1'b0, 16'h0000, 16'h0000};
   prog[11] = '{16'h820B, 16'h7383, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b1, 16'h0043, 16'hFFFD};
   prog[12] = '{16'h820C, 16'h71BE, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b1, 16'h003E, 16'h0005};
   prog[13] = '{16'h820D, 16'h6783, 1'b1, 3'd3, 16'hFFFD, 3'b100, 1'b0, 16'h0043, 16'hFFFD};
   prog[14] = '{16'h820E, 16'h65BE, 1'b1, 3'd2, 16'h0005, 3'b001, 1'b0, 16'h003E, 16'h0005};
   // BRn falls through on P, BRzp skips two words
   prog[15] = '{16'h820F, 16'h0805, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   prog[16] = '{16'h8210, 16'h0602, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   // JMP +4 lands on 8218
   prog[17] = '{16'h8213, 16'hC804, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   // Z from CONST #0, BRnp falls through, BRz goes back to 8217
   prog[18] = '{16'h8218, 16'h9A00, 1'b1, 3'd5, 16'h0000, 3'b010, 1'b0, 16'h0000, 16'h0000};
   prog[19] = '{16'h8219, 16'h0A05, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   prog[20] = '{16'h821A, 16'h05FC, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   // JSR to 8300, link value is negative
   prog[21] = '{16'h8217, 16'h4830, 1'b1, 3'd7, 16'h8218, 3'b100, 1'b0, 16'h0000, 16'h0000};
   // R4 = R7 + 8, then JSRR R4 and JMPR R7 back
   prog[22] = '{16'h8300, 16'h19E8, 1'b1, 3'd4, 16'h8220, 3'b100, 1'b0, 16'h0000, 16'h0000};
   prog[23] = '{16'h8301, 16'h4100, 1'b1, 3'd7, 16'h8302, 3'b100, 1'b0, 16'h0000, 16'h0000};
   prog[24] = '{16'h8220, 16'hC1C0, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   // MUL retires as a no-op
   prog[25] = '{16'h8302, 16'h1208, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   // TRAP x25 into the vector page
   prog[26] = '{16'h8303, 16'hF025, 1'b1, 3'd7, 16'h8304, 3'b100, 1'b0, 16'h0000, 16'h0000};
   prog[27] = '{16'h8025, 16'h1000, 1'b1, 3'd0, 16'h000A, 3'b001, 1'b0, 16'h0000, 16'h0000};
   // HICONST is not kept
   prog[28] = '{16'h8026, 16'hD1FF, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000};
   prog[29] = '{16'h8027, 16'h1210, 1'b1, 3'd1, 16'h0000, 3'b010, 1'b0, 16'h0000, 16'h0000};
endtask

`endif

// File: testbench/tb_lc4_core.sv
`timescale 1ns/1ps
`include "lc4_params.svh"

module tb_lc4_core;

   localparam int CLK_HALF     = 50;
   localparam int DRIVE_DELAY  = 10;
   localparam int CHECK_DELAY  = 20;
   localparam int RESET_CYCLES = 8;
   localparam int MEM_WORDS    = 1 << `LC4_WORD_W;

   // Program words and expected trace rows
   `include "tb_lc4_program.svh"

   localparam int ROW_IDX_W   = $clog2(PROG_ROWS);
   // One row per cycle, plus reset and some slack
   localparam int CYCLE_LIMIT = PROG_ROWS + RESET_CYCLES + 20;

   logic                   gwe;
   logic                   i_arst_n;
   logic [`LC4_WORD_W-1:0] imem_addr;
   logic [`LC4_WORD_W-1:0] imem_data;
   logic [`LC4_WORD_W-1:0] dmem_addr;
   logic                   dmem_we;
   logic [`LC4_WORD_W-1:0] dmem_wdata;
   logic [`LC4_WORD_W-1:0] dmem_rdata;
   lc4_pkg::lc4_trace_t    trace;

   // Full 64K word spaces for both memories
   logic [`LC4_WORD_W-1:0] imem [MEM_WORDS];
   logic [`LC4_WORD_W-1:0] dmem [MEM_WORDS];
   int                     cycle_count;

   lc4_core u_lc4_core (
      .gwe          (gwe),
      .i_arst_n     (i_arst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_data  (imem_data),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_we    (dmem_we),
      .o_dmem_wdata (dmem_wdata),
      .i_dmem_rdata (dmem_rdata),
      .o_trace      (trace)
   );

   // Both memories answer combinationally
   assign imem_data  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_addr];

   // Store strobe commits on the edge
   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr] <= dmem_wdata;
      end
   end

   initial begin : clock_gen
      gwe = 1'b0;
      forever begin
         #CLK_HALF gwe = ~gwe;
      end
   end

   // Words never fetched by a correct core, byte swapped and masked
   function automatic logic [`LC4_WORD_W-1:0] fill_word(input logic [`LC4_WORD_W-1:0] addr);
      return {addr[7:0], addr[15:8]} ^ 16'hC3A5;
   endfunction

   task automatic compare_field(input string field, input logic [`LC4_WORD_W-1:0] actual,
                                input logic [`LC4_WORD_W-1:0] expected);
      if (actual !== expected) begin
         $display("ERROR: %t: %s mismatch at pc %h, got %h, expected %h",
                  $time, field, trace.pc, actual, expected);
         $display("SIMULATION FAILED");
         $fatal(1, "Trace check failed");
      end
   endtask

   task automatic check_row(input prog_row_t row);
      compare_field("pc", trace.pc, row.pc);
      compare_field("insn", trace.insn, row.insn);
      compare_field("rf_we", 16'(trace.rf_we), 16'(row.rf_we));
      // NZP moves exactly when a register is written
      compare_field("nzp_we", 16'(trace.nzp_we), 16'(row.rf_we));
      compare_field("dmem_we", 16'(trace.dmem_we), 16'(row.dmem_we));
      compare_field("dmem_addr", trace.dmem_addr, row.dmem_addr);
      compare_field("dmem_data", trace.dmem_data, row.dmem_data);
      // Memory ports of the core
      compare_field("o_imem_addr", imem_addr, row.pc);
      compare_field("o_dmem_we", 16'(dmem_we), 16'(row.dmem_we));
      compare_field("o_dmem_addr", dmem_addr, row.dmem_addr);
      if (row.dmem_we) begin
         compare_field("o_dmem_wdata", dmem_wdata, row.dmem_data);
      end
      // Write port fields only mean something with rf_we set
      if (row.rf_we) begin
         compare_field("rf_wsel", 16'(trace.rf_wsel), 16'(row.rf_wsel));
         compare_field("rf_wdata", trace.rf_wdata, row.rf_wdata);
         compare_field("nzp_new", 16'(trace.nzp_new), 16'(row.nzp_new));
      end
   endtask

   initial begin : watchdog
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge gwe);
         cycle_count = cycle_count + 1;
      end
      $display("Timeout: the program did not complete within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial begin : stimulus
      logic [ROW_IDX_W-1:0] idx;
      $timeformat(-9, 0, " ns", 0);
      i_arst_n = 1'b0;
      for (int a = 0; a < MEM_WORDS; a++) begin
         imem[a[`LC4_WORD_W-1:0]] = fill_word(a[`LC4_WORD_W-1:0]);
      end
      // Program words go to the pc each row expects
      fill_program_table();
      for (int k = 0; k < PROG_ROWS; k++) begin
         idx = k[ROW_IDX_W-1:0];
         imem[prog[idx].pc] = prog[idx].insn;
      end

      repeat (RESET_CYCLES) @(posedge gwe);
      #DRIVE_DELAY;
      i_arst_n = 1'b1;
      #(CHECK_DELAY - DRIVE_DELAY);

      // Trace shows the row about to retire on the next edge
      for (int r = 0; r < PROG_ROWS; r++) begin
         if (r > 0) begin
            @(posedge gwe);
            #CHECK_DELAY;
         end
         idx = r[ROW_IDX_W-1:0];
         check_row(prog[idx]);
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: logic/lc4_core.sv
`timescale 1ns/1ps
`include "lc4_params.svh"

module lc4_core (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   output logic [`LC4_WORD_W-1:0] o_imem_addr,
   input  logic [`LC4_WORD_W-1:0] i_imem_data,
   output logic [`LC4_WORD_W-1:0] o_dmem_addr,
   output logic                   o_dmem_we,
   output logic [`LC4_WORD_W-1:0] o_dmem_wdata,
   input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
   output lc4_pkg::lc4_trace_t    o_trace
);

   lc4_pkg::lc4_ctrl_t     ctrl;
   logic [`LC4_WORD_W-1:0] rs_data;
   logic [`LC4_WORD_W-1:0] rt_data;
   logic [`LC4_WORD_W-1:0] alu_result;
   logic [`LC4_WORD_W-1:0] pc;
   logic [`LC4_WORD_W-1:0] pc_plus_one;
   logic [`LC4_WORD_W-1:0] wdata;
   logic [2:0]             nzp_new;
   // Load or store this cycle
   logic                   mem_access;

   lc4_decoder u_decoder (
      .i_insn (i_imem_data),
      .o_ctrl (ctrl)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs_sel  (ctrl.rs_sel),
      .i_rt_sel  (ctrl.rt_sel),
      .i_rd_sel  (ctrl.rd_sel),
      .i_we      (ctrl.rf_we),
      .i_wdata   (wdata),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   lc4_alu u_alu (
      .i_ctrl    (ctrl),
      .i_insn    (i_imem_data),
      .i_rs_data (rs_data),
      .i_rt_data (rt_data),
      .o_result  (alu_result)
   );

   lc4_pc_unit u_pc_unit (
      .gwe           (gwe),
      .i_arst_n      (i_arst_n),
      .i_ctrl        (ctrl),
      .i_insn        (i_imem_data),
      .i_rs_data     (rs_data),
      .i_wdata       (wdata),
      .o_pc          (pc),
      .o_pc_plus_one (pc_plus_one),
      .o_nzp_new     (nzp_new)
   );

   // Fetch address is the PC itself
   assign o_imem_addr = pc;

   // Writeback select
   always_comb begin
      case (ctrl.wb_src)
         lc4_pkg::WB_MEM: wdata = i_dmem_rdata;
         // Return address into R7
         lc4_pkg::WB_PC1: wdata = pc_plus_one;
         default:         wdata = alu_result;
      endcase
   end

   // Data memory port, address zeroed when unused
   assign mem_access   = ctrl.is_load || ctrl.is_store;
   assign o_dmem_addr  = mem_access ? alu_result : '0;
   assign o_dmem_we    = ctrl.is_store;
   assign o_dmem_wdata = ctrl.is_store ? rt_data : '0;

   // Trace of the instruction at the current PC
   always_comb begin
      o_trace.pc        = pc;
      o_trace.insn      = i_imem_data;
      o_trace.rf_we     = ctrl.rf_we;
      o_trace.rf_wsel   = ctrl.rd_sel;
      o_trace.rf_wdata  = wdata;
      o_trace.nzp_we    = ctrl.nzp_we;
      o_trace.nzp_new   = nzp_new;
      o_trace.dmem_we   = o_dmem_we;
      o_trace.dmem_addr = o_dmem_addr;
      // Loaded word for LDR, stored word for STR
      o_trace.dmem_data = ctrl.is_load ? i_dmem_rdata : o_dmem_wdata;
   end

endmodule

// File: logic/lc4_pc_unit.sv
`timescale 1ns/1ps
`include "lc4_params.svh"

module lc4_pc_unit (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   input  lc4_pkg::lc4_ctrl_t     i_ctrl,
   input  logic [`LC4_WORD_W-1:0] i_insn,
   input  logic [`LC4_WORD_W-1:0] i_rs_data,
   input  logic [`LC4_WORD_W-1:0] i_wdata,
   output logic [`LC4_WORD_W-1:0] o_pc,
   output logic [`LC4_WORD_W-1:0] o_pc_plus_one,
   output logic [2:0]             o_nzp_new
);

   localparam int W = `LC4_WORD_W;
   localparam logic [W-1:0] ONE = 1;

   logic [W-1:0] pc_q;
   logic [W-1:0] pc_plus_one;
   logic [W-1:0] next_pc;
   logic [W-1:0] br_target;
   logic [W-1:0] jmp_target;
   logic [W-1:0] jsr_target;
   logic [W-1:0] trap_target;
   // Stored condition codes, N Z P from msb down
   logic [2:0]   nzp_q;
   logic         br_taken;

   assign pc_plus_one   = pc_q + ONE;
   assign o_pc          = pc_q;
   assign o_pc_plus_one = pc_plus_one;

   // Condition codes of the value being written back
   always_comb begin
      if (i_wdata[W-1]) begin
         o_nzp_new = 3'b100;
      end else if (i_wdata == '0) begin
         o_nzp_new = 3'b010;
      end else begin
         o_nzp_new = 3'b001;
      end
   end

   // Any mask bit in insn[11:9] that meets a set NZP bit
   assign br_taken = i_ctrl.is_branch && |(i_insn[11:9] & nzp_q);

   // PC-relative targets count from PC plus one
   assign br_target   = pc_plus_one + {{(W-9){i_insn[8]}}, i_insn[8:0]};
   assign jmp_target  = pc_plus_one + {{(W-11){i_insn[10]}}, i_insn[10:0]};
   // Page bit of the PC kept, imm11 scaled by 16
   assign jsr_target  = {pc_q[W-1], i_insn[10:0], 4'b0000};
   assign trap_target = `LC4_TRAP_BASE | {{(W-8){1'b0}}, i_insn[7:0]};

   always_comb begin
      case (i_ctrl.flow)
         lc4_pkg::FLOW_BRANCH:  next_pc = br_taken ? br_target : pc_plus_one;
         lc4_pkg::FLOW_JMP_REL: next_pc = jmp_target;
         // JMPR and JSRR, Rs read before R7 is overwritten
         lc4_pkg::FLOW_JMP_REG: next_pc = i_rs_data;
         lc4_pkg::FLOW_JSR_ABS: next_pc = jsr_target;
         lc4_pkg::FLOW_TRAP:    next_pc = trap_target;
         default:               next_pc = pc_plus_one;
      endcase
   end

   // One instruction retires on every edge
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q  <= `LC4_RESET_PC;
         nzp_q <= 3'b000;
      end else begin
         pc_q <= next_pc;
         if (i_ctrl.nzp_we) begin
            nzp_q <= o_nzp_new;
         end
      end
   end

endmodule

// File: logic/lc4_alu.sv
`timescale 1ns/1ps
`include "lc4_params.svh"

module lc4_alu (
   input  lc4_pkg::lc4_ctrl_t     i_ctrl,
   input  logic [`LC4_WORD_W-1:0] i_insn,
   input  logic [`LC4_WORD_W-1:0] i_rs_data,
   input  logic [`LC4_WORD_W-1:0] i_rt_data,
   output logic [`LC4_WORD_W-1:0] o_result
);

   localparam int W = `LC4_WORD_W;

   // Sign-extended immediates
   // imm5 for ADDI and ANDI
   logic [W-1:0] imm5;
   // imm6 for the LDR and STR offset
   logic [W-1:0] imm6;
   // imm9 for CONST
   logic [W-1:0] imm9;
   // Second operand, register or imm5
   logic [W-1:0] op_b;

   assign imm5 = {{(W-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{(W-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{(W-9){i_insn[8]}}, i_insn[8:0]};

   assign op_b = i_ctrl.use_imm ? imm5 : i_rt_data;

   always_comb begin
      case (i_ctrl.alu_op)
         lc4_pkg::ALU_ADD: begin
            o_result = i_rs_data + op_b;
         end
         lc4_pkg::ALU_SUB: begin
            // Two's complement wrap, same as the ISA
            o_result = i_rs_data - op_b;
         end
         lc4_pkg::ALU_AND: begin
            o_result = i_rs_data & op_b;
         end
         lc4_pkg::ALU_NOT: begin
            o_result = ~i_rs_data;
         end
         lc4_pkg::ALU_OR: begin
            o_result = i_rs_data | op_b;
         end
         lc4_pkg::ALU_XOR: begin
            o_result = i_rs_data ^ op_b;
         end
         lc4_pkg::ALU_PASS_IMM: begin
            o_result = imm9;
         end
         lc4_pkg::ALU_ADDR: begin
            // Effective address for loads and stores
            o_result = i_rs_data + imm6;
         end
         default: begin
            o_result = '0;
         end
      endcase
   end

endmodule

// File: logic/lc4_regfile.sv
`timescale 1ns/1ps
`include "lc4_params.svh"

module lc4_regfile (
   input  logic                      gwe,
   input  logic                      i_arst_n,
   input  logic [`LC4_REG_SEL_W-1:0] i_rs_sel,
   input  logic [`LC4_REG_SEL_W-1:0] i_rt_sel,
   input  logic [`LC4_REG_SEL_W-1:0] i_rd_sel,
   input  logic                      i_we,
   input  logic [`LC4_WORD_W-1:0]    i_wdata,
   output logic [`LC4_WORD_W-1:0]    o_rs_data,
   output logic [`LC4_WORD_W-1:0]    o_rt_data
);

   localparam int REG_COUNT = 1 << `LC4_REG_SEL_W;

   // R0 to R7, all general purpose
   logic [`LC4_WORD_W-1:0] regs [REG_COUNT];

   // Combinational reads, no bypass from the write port
   assign o_rs_data = regs[i_rs_sel];
   assign o_rt_data = regs[i_rt_sel];

   // Single write port, committed on the gwe edge
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

endmodule

// File: logic/lc4_decoder.sv
`timescale 1ns/1ps
`include "lc4_params.svh"

module lc4_decoder (
   input  logic [`LC4_WORD_W-1:0] i_insn,
   output lc4_pkg::lc4_ctrl_t     o_ctrl
);

   // Link register for JSR, JSRR and TRAP
   localparam logic [`LC4_REG_SEL_W-1:0] REG_R7 = {`LC4_REG_SEL_W{1'b1}};

   lc4_pkg::opcode_e opcode;
   // Sub-opcode of the ADD and LOGIC groups
   logic [2:0]       sub_op;
   // Immediate form of ADD and AND
   logic             imm_form;

   assign opcode   = lc4_pkg::opcode_e'(i_insn[15:12]);
   assign sub_op   = i_insn[5:3];
   assign imm_form = i_insn[5];

   always_comb begin
      // Start from a sequential no-op
      o_ctrl        = '0;
      o_ctrl.rs_sel = i_insn[8:6];
      o_ctrl.rt_sel = i_insn[2:0];
      o_ctrl.rd_sel = i_insn[11:9];
      o_ctrl.alu_op = lc4_pkg::ALU_ADD;
      o_ctrl.wb_src = lc4_pkg::WB_ALU;
      o_ctrl.flow   = lc4_pkg::FLOW_SEQ;

      case (opcode)
         lc4_pkg::OP_BR: begin
            // NZP mask lives in insn[11:9], tested in the PC unit
            o_ctrl.is_branch = 1'b1;
            o_ctrl.flow      = lc4_pkg::FLOW_BRANCH;
         end
         lc4_pkg::OP_ADD: begin
            // Only ADD, SUB and ADDI, MUL and DIV fall through as no-ops
            if (imm_form || sub_op == 3'b000 || sub_op == 3'b010) begin
               o_ctrl.rf_we   = 1'b1;
               o_ctrl.nzp_we  = 1'b1;
               o_ctrl.use_imm = imm_form;
               o_ctrl.alu_op  = (!imm_form && sub_op == 3'b010) ?
                                lc4_pkg::ALU_SUB : lc4_pkg::ALU_ADD;
            end
         end
         lc4_pkg::OP_LOGIC: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            if (imm_form) begin
               o_ctrl.use_imm = 1'b1;
               o_ctrl.alu_op  = lc4_pkg::ALU_AND;
            end else begin
               // With insn[5] clear two sub-op bits remain
               case (sub_op[1:0])
                  2'b00: o_ctrl.alu_op = lc4_pkg::ALU_AND;
                  2'b01: o_ctrl.alu_op = lc4_pkg::ALU_NOT;
                  2'b10: o_ctrl.alu_op = lc4_pkg::ALU_OR;
                  2'b11: o_ctrl.alu_op = lc4_pkg::ALU_XOR;
               endcase
            end
         end
         lc4_pkg::OP_LDR: begin
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.is_load = 1'b1;
            o_ctrl.alu_op  = lc4_pkg::ALU_ADDR;
            o_ctrl.wb_src  = lc4_pkg::WB_MEM;
         end
         lc4_pkg::OP_STR: begin
            // Store data register sits where Rd normally is
            o_ctrl.rt_sel   = i_insn[11:9];
            o_ctrl.is_store = 1'b1;
            o_ctrl.alu_op   = lc4_pkg::ALU_ADDR;
         end
         lc4_pkg::OP_CONST: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = lc4_pkg::ALU_PASS_IMM;
         end
         lc4_pkg::OP_JSR: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.rd_sel = REG_R7;
            o_ctrl.wb_src = lc4_pkg::WB_PC1;
            // insn[11] picks JSR over JSRR
            o_ctrl.flow   = i_insn[11] ? lc4_pkg::FLOW_JSR_ABS : lc4_pkg::FLOW_JMP_REG;
         end
         lc4_pkg::OP_JMP: begin
            o_ctrl.flow = i_insn[11] ? lc4_pkg::FLOW_JMP_REL : lc4_pkg::FLOW_JMP_REG;
         end
         lc4_pkg::OP_TRAP: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.rd_sel = REG_R7;
            o_ctrl.wb_src = lc4_pkg::WB_PC1;
            o_ctrl.flow   = lc4_pkg::FLOW_TRAP;
         end
         default: begin
            // CMP, RTI, shifts, HICONST and the rest retire as no-ops
            o_ctrl.flow = lc4_pkg::FLOW_SEQ;
         end
      endcase
   end

endmodule

// File: logic/lc4_pkg.sv
`include "lc4_params.svh"

package lc4_pkg;

   // Major opcode in insn[15:12], only the supported groups are named
   typedef enum logic [3:0] {
      OP_BR    = 4'h0,
      OP_ADD   = 4'h1,
      OP_JSR   = 4'h4,
      OP_LOGIC = 4'h5,
      OP_LDR   = 4'h6,
      OP_STR   = 4'h7,
      OP_CONST = 4'h9,
      OP_JMP   = 4'hC,
      OP_TRAP  = 4'hF
   } opcode_e;

   // ALU function select
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_NOT,
      ALU_OR,
      ALU_XOR,
      // CONST result, sign-extended imm9
      ALU_PASS_IMM,
      // Rs plus imm6 for loads and stores
      ALU_ADDR
   } alu_op_e;

   // Register writeback source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_PC1
   } wb_src_e;

   // Next-PC selection
   typedef enum logic [2:0] {
      FLOW_SEQ,
      FLOW_BRANCH,
      FLOW_JMP_REL,
      FLOW_JMP_REG,
      FLOW_JSR_ABS,
      FLOW_TRAP
   } flow_e;

   // Decoded control bundle, one per instruction
   typedef struct packed {
      logic [`LC4_REG_SEL_W-1:0] rs_sel;
      logic [`LC4_REG_SEL_W-1:0] rt_sel;
      logic [`LC4_REG_SEL_W-1:0] rd_sel;
      logic                      rf_we;
      logic                      nzp_we;
      alu_op_e                   alu_op;
      logic                      use_imm;
      wb_src_e                   wb_src;
      logic                      is_load;
      logic                      is_store;
      logic                      is_branch;
      flow_e                     flow;
   } lc4_ctrl_t;

   // Per-instruction retire record for the testbench
   typedef struct packed {
      logic [`LC4_WORD_W-1:0]    pc;
      logic [`LC4_WORD_W-1:0]    insn;
      logic                      rf_we;
      logic [`LC4_REG_SEL_W-1:0] rf_wsel;
      logic [`LC4_WORD_W-1:0]    rf_wdata;
      logic                      nzp_we;
      logic [2:0]                nzp_new;
      logic                      dmem_we;
      logic [`LC4_WORD_W-1:0]    dmem_addr;
      logic [`LC4_WORD_W-1:0]    dmem_data;
   } lc4_trace_t;

endpackage

// File: logic/lc4_params.svh
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// Core-wide sizing and fixed addresses

// Data word and address width
`define LC4_WORD_W 16

// Register index width, eight general registers
`define LC4_REG_SEL_W 3

// Boot address of the first user instruction
`define LC4_RESET_PC 16'h8200

// Base of the trap vector table
// TRAP lands here with its eight-bit vector in the low byte
`define LC4_TRAP_BASE 16'h8000

`endif
